// ==== logic/scan_consts.svh ====
`ifndef SCAN_CONSTS_SVH
`define SCAN_CONSTS_SVH

// Number of interleaved stream contexts held by each scanner
`define SCAN_STREAMS 64

// Matcher state width, enough to count the characters of the longest keyword
`define SCAN_STATE_W 4

// Width of the match and flagged-packet counters
`define SCAN_COUNT_W 16

// Longest keyword the scanner accepts, in characters
`define SCAN_KEY_MAX 8

`endif

// ==== logic/scan_pkg.sv ====
`default_nettype none

`include "scan_consts.svh"

package scan_pkg;

  // One character off the bus
  typedef logic [7:0] scan_char_t;

  // Number of keyword characters matched so far
  typedef logic [`SCAN_STATE_W-1:0] scan_state_t;

  // Keyword with its first character in the low byte
  typedef logic [8*`SCAN_KEY_MAX-1:0] scan_key_t;

  // Keyword character at a given match position
  function automatic scan_char_t key_byte(input scan_key_t key, input scan_state_t pos);
    return key[8*int'(pos[$clog2(`SCAN_KEY_MAX)-1:0]) +: 8];
  endfunction

  // A string literal holds its first character in the top byte,
  // so flip the byte order to get the keyword layout
  function automatic scan_key_t key_from_str(input scan_key_t text, input int len);
    scan_key_t key;
    key = '0;
    for (int i = 0; i < `SCAN_KEY_MAX; i++)
    begin
      if (i < len)
        key[8*i +: 8] = text[8*(len-1-i) +: 8];
    end
    return key;
  endfunction

endpackage

`default_nettype wire

// ==== logic/stream_pkg.sv ====
`default_nettype none

`include "scan_consts.svh"

package stream_pkg;

  // Index of one of the interleaved streams
  typedef logic [$clog2(`SCAN_STREAMS)-1:0] stream_id_t;

  // Match and packet counters
  typedef logic [`SCAN_COUNT_W-1:0] count_t;

  // Packet verdict with bit 0 for the read command and bit 1 for the post command
  typedef enum logic [1:0] {
    CAT_NONE = 2'b00,
    CAT_READ = 2'b01,
    CAT_POST = 2'b10,
    CAT_BOTH = 2'b11
  } category_t;

  // Fold the two scanner reports into one verdict
  function automatic category_t encode_category(input logic read_hit, input logic post_hit);
    return category_t'({post_hit, read_hit});
  endfunction

endpackage

`default_nettype wire

// ==== logic/char_bus_if.sv ====
`default_nettype none
`timescale 1ns/10ps

// Character bus shared by both keyword scanners
interface char_bus_if import scan_pkg::*, stream_pkg::*; ();

  // One character per strobe
  scan_char_t char_in;
  logic       char_vld;

  // Packet start picks the stream context to restore
  logic       load_state;
  stream_id_t stream_id;
  logic       new_stream;

  // Packet end pulse with stream_id still held
  logic       eop;

  // Top level drives the bus
  modport src (
    output char_in, char_vld, load_state, stream_id, new_stream, eop
  );

  // Scanners only listen
  modport scan (
    input char_in, char_vld, load_state, stream_id, new_stream, eop
  );

endinterface

`default_nettype wire

// ==== logic/keyword_scanner.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "scan_consts.svh"

module keyword_scanner import scan_pkg::*, stream_pkg::*; #(
  parameter scan_key_t keyword = '0,
  parameter int        key_len = 1
) (
  input  wire logic   clk,
  input  wire logic   rst_n,
  char_bus_if.scan    bus,
  input  wire logic   enable,
  output logic        fired,
  output count_t      count,
  output logic        result_vld,
  output logic        result_fired
);

  // State value that completes the keyword
  localparam scan_state_t key_end = scan_state_t'(key_len);

  // Bus input registers
  scan_char_t char_r;
  logic       char_vld_r;
  logic       load_r;
  logic       new_stream_r;
  logic       eop_r;
  logic       enable_r;
  stream_id_t stream_id_r;

  // Second character stage in front of the matcher
  scan_char_t char_rr;
  logic       char_vld_rr;

  // Per-stream saved matcher state
  scan_state_t ctx_mem [`SCAN_STREAMS];

  // Restored state waiting to enter the matcher
  scan_state_t state_in;
  logic        state_in_vld;

  // Matcher
  scan_state_t state;
  scan_state_t state_nxt;
  logic        hit;
  logic        hit_nxt;

  // Control side of the input registers
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      char_vld_r  <= 1'b0;
      char_vld_rr <= 1'b0;
      load_r      <= 1'b0;
      eop_r       <= 1'b0;
    end
    else
    begin
      char_vld_r  <= bus.char_vld;
      char_vld_rr <= char_vld_r;
      load_r      <= bus.load_state;
      eop_r       <= bus.eop;
    end
  end

  // Payload side of the input registers
  always_ff @(posedge clk)
  begin
    char_r       <= bus.char_in;
    char_rr      <= char_r;
    stream_id_r  <= bus.stream_id;
    new_stream_r <= bus.new_stream;
    enable_r     <= enable;
  end

  // Context restore one cycle after the sampled load_state
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      state_in_vld <= 1'b0;
    else
      state_in_vld <= load_r;
  end

  // Fresh stream starts from zero and a known stream resumes its saved state
  always_ff @(posedge clk)
  begin
    if (load_r)
      state_in <= new_stream_r ? '0 : ctx_mem[stream_id_r];
  end

  // Next state for the current character
  always_comb
  begin
    hit_nxt = 1'b0;
    if (char_rr == key_byte(keyword, state))
      state_nxt = state + 1'b1;
    // Mismatch may still open a new match on the first character
    else if (char_rr == key_byte(keyword, '0))
      state_nxt = scan_state_t'(1);
    else
      state_nxt = '0;
    // Full keyword seen and the match starts over
    if (state_nxt == key_end)
    begin
      hit_nxt   = 1'b1;
      state_nxt = '0;
    end
  end

  // Matcher state takes a restore two cycles after load_state
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state <= '0;
      hit   <= 1'b0;
    end
    else if (state_in_vld)
    begin
      state <= state_in;
      hit   <= 1'b0;
    end
    else if (char_vld_rr)
    begin
      state <= state_nxt;
      hit   <= hit_nxt;
    end
    else
      hit <= 1'b0;
  end

  // Speculative fired flag for the current packet
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      fired <= 1'b0;
    else if (load_r)
      fired <= 1'b0;
    else if (hit)
      fired <= 1'b1;
    // Disabled scanner drops whatever it found
    else if (eop_r && !enable_r)
      fired <= 1'b0;
  end

  // Packet end report and running count
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      count        <= '0;
      result_vld   <= 1'b0;
      result_fired <= 1'b0;
    end
    else
    begin
      result_vld <= eop_r;
      if (eop_r)
      begin
        result_fired <= enable_r & fired;
        if (enable_r)
          count <= count + count_t'(fired);
      end
    end
  end

  // Save the context only when the scanner is enabled for this stream
  always_ff @(posedge clk)
  begin
    if (eop_r && enable_r)
      ctx_mem[stream_id_r] <= state;
  end

endmodule

`default_nettype wire

// ==== logic/category_tally.sv ====
`default_nettype none
`timescale 1ns/10ps

module category_tally import stream_pkg::*; (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic read_vld,
  input  wire logic read_fired,
  input  wire logic post_vld,
  input  wire logic post_fired,
  output logic      verdict_vld,
  output category_t verdict,
  output count_t    flagged_count
);

  // Both pulses land in the same cycle so either one marks the pair
  logic      pair_vld;
  category_t cat_nxt;

  always_comb
  begin
    pair_vld = read_vld | post_vld;
    // A report only counts together with its pulse
    cat_nxt  = encode_category(read_vld & read_fired, post_vld & post_fired);
  end

  // Verdict one cycle after the scanner reports
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      verdict_vld   <= 1'b0;
      verdict       <= CAT_NONE;
      flagged_count <= '0;
    end
    else
    begin
      verdict_vld <= pair_vld;
      if (pair_vld)
      begin
        verdict <= cat_nxt;
        // Any keyword in the packet flags it
        if (cat_nxt != CAT_NONE)
          flagged_count <= flagged_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/nntp_classifier.sv ====
`default_nettype none
`timescale 1ns/10ps

module nntp_classifier import scan_pkg::*, stream_pkg::*; (
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire scan_char_t char_in,
  input  wire logic       char_vld,
  input  wire logic       load_state,
  input  wire stream_id_t stream_id,
  input  wire logic       new_stream,
  input  wire logic       eop,
  input  wire logic       enable_read,
  input  wire logic       enable_post,
  output logic            fired_read,
  output logic            fired_post,
  output count_t          count_read,
  output count_t          count_post,
  output logic            verdict_vld,
  output category_t       verdict,
  output count_t          flagged_count
);

  // Scanner reports into the tally
  logic read_vld;
  logic read_fired;
  logic post_vld;
  logic post_fired;

  char_bus_if bus ();

  // Drive the shared bus from the top-level ports
  assign bus.char_in    = char_in;
  assign bus.char_vld   = char_vld;
  assign bus.load_state = load_state;
  assign bus.stream_id  = stream_id;
  assign bus.new_stream = new_stream;
  assign bus.eop        = eop;

  // Read command scanner
  keyword_scanner #(
    .keyword (key_from_str("ARTICLE", 7)),
    .key_len (7)
  ) read_scan (
    .clk          (clk),
    .rst_n        (rst_n),
    .bus          (bus.scan),
    .enable       (enable_read),
    .fired        (fired_read),
    .count        (count_read),
    .result_vld   (read_vld),
    .result_fired (read_fired)
  );

  // Post command scanner
  keyword_scanner #(
    .keyword (key_from_str("POST", 4)),
    .key_len (4)
  ) post_scan (
    .clk          (clk),
    .rst_n        (rst_n),
    .bus          (bus.scan),
    .enable       (enable_post),
    .fired        (fired_post),
    .count        (count_post),
    .result_vld   (post_vld),
    .result_fired (post_fired)
  );

  // Verdict two cycles after eop
  category_tally tally (
    .clk           (clk),
    .rst_n         (rst_n),
    .read_vld      (read_vld),
    .read_fired    (read_fired),
    .post_vld      (post_vld),
    .post_fired    (post_fired),
    .verdict_vld   (verdict_vld),
    .verdict       (verdict),
    .flagged_count (flagged_count)
  );

endmodule

`default_nettype wire

// ==== sim/nntp_classifier_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

module nntp_classifier_tb import scan_pkg::*, stream_pkg::*; ();

  // One packet of the table where '*' in the text stands for random lowercase filler
  typedef struct {
    string     name;
    int        sid;
    bit        fresh;
    bit        en_read;
    bit        en_post;
    string     text;
    category_t exp;
  } packet_row_t;

  logic       clk;
  logic       rst_n;
  scan_char_t char_in;
  logic       char_vld;
  logic       load_state;
  stream_id_t stream_id;
  logic       new_stream;
  logic       eop;
  logic       enable_read;
  logic       enable_post;
  logic       fired_read;
  logic       fired_post;
  count_t     count_read;
  count_t     count_post;
  logic       verdict_vld;
  category_t  verdict;
  count_t     flagged_count;

  packet_row_t rows [$];
  string       read_key = "ARTICLE";
  string       post_key = "POST";

  // Reference model contexts and expected counters
  int read_ctx [64];
  int post_ctx [64];
  int exp_read_count;
  int exp_post_count;
  int exp_flagged;

  int value_errors;
  int missing_errors;
  int checks;
  int limit_cycles;

  nntp_classifier dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .char_in       (char_in),
    .char_vld      (char_vld),
    .load_state    (load_state),
    .stream_id     (stream_id),
    .new_stream    (new_stream),
    .eop           (eop),
    .enable_read   (enable_read),
    .enable_post   (enable_post),
    .fired_read    (fired_read),
    .fired_post    (fired_post),
    .count_read    (count_read),
    .count_post    (count_post),
    .verdict_vld   (verdict_vld),
    .verdict       (verdict),
    .flagged_count (flagged_count)
  );

  always #20 clk = ~clk;

  task automatic add_row(input string name, input int sid, input bit fresh, input bit en_read,
                         input bit en_post, input string text, input category_t exp);
    packet_row_t r;
    r.name    = name;
    r.sid     = sid;
    r.fresh   = fresh;
    r.en_read = en_read;
    r.en_post = en_post;
    r.text    = text;
    r.exp     = exp;
    rows.push_back(r);
  endtask

  task automatic build_table();
    add_row("read_new", 1, 1, 1, 1, "*ARTICLE*", CAT_READ);
    add_row("post_new", 2, 1, 1, 1, "*POST*", CAT_POST);
    add_row("both_new", 4, 1, 1, 1, "*ARTICLE*POST*", CAT_BOTH);
    // Split keyword on stream 3 with stream 9 in between
    add_row("split_first", 3, 1, 1, 1, "*ARTI", CAT_NONE);
    add_row("other_stream", 9, 1, 1, 1, "*POST*ARTIC*", CAT_POST);
    add_row("split_second", 3, 0, 1, 1, "CLE*", CAT_READ);
    // Same split with new_stream on the second half
    add_row("restart_first", 7, 1, 1, 1, "*PO", CAT_NONE);
    add_row("restart_second", 7, 1, 1, 1, "ST*", CAT_NONE);
    add_row("read_disabled", 5, 1, 0, 1, "*ARTICLE*", CAT_NONE);
    add_row("post_disabled", 12, 1, 1, 0, "*POST*", CAT_NONE);
    // Disabled packet in the middle must leave the saved partial alone
    add_row("nosave_first", 6, 1, 1, 1, "*ARTI", CAT_NONE);
    add_row("nosave_middle", 6, 0, 0, 1, "ART", CAT_NONE);
    add_row("nosave_last", 6, 0, 1, 1, "CLE*", CAT_READ);
    add_row("near_miss", 8, 1, 1, 1, "*ARTICXE*", CAT_NONE);
    add_row("popost", 10, 1, 1, 1, "*POPOST*", CAT_POST);
    add_row("top_stream", 63, 1, 1, 1, "*ARTICLEPOST*", CAT_BOTH);
  endtask

  // Matcher rule for one character
  function automatic int advance_match(input string key, input int st, input byte c,
                                       output bit done);
    int nxt;
    if (c == key[st])
      nxt = st + 1;
    else if (c == key[0])
      nxt = 1;
    else
      nxt = 0;
    done = (nxt == key.len());
    if (done)
      nxt = 0;
    return nxt;
  endfunction

  function automatic category_t expected_category(input bit read_hit, input bit post_hit);
    if (read_hit && post_hit)
      return CAT_BOTH;
    if (read_hit)
      return CAT_READ;
    if (post_hit)
      return CAT_POST;
    return CAT_NONE;
  endfunction

  task automatic check_value(input string test, input string what, input int exp, input int act);
    checks++;
    assert (exp == act)
    else
    begin
      value_errors++;
      $display("Fail %s %s expected %0d actual %0d", test, what, exp, act);
    end
  endtask

  task automatic print_counts();
    $display("Checks %0d, value errors %0d, missing verdicts %0d",
             checks, value_errors, missing_errors);
  endtask

  // Sends load, characters and eop with the bus spacing and returns on the eop edge
  task automatic drive_packet(input packet_row_t r, input byte chars [$]);
    repeat ($urandom_range(4, 1)) @(posedge clk);
    load_state  <= 1'b1;
    stream_id   <= stream_id_t'(r.sid);
    new_stream  <= r.fresh;
    enable_read <= r.en_read;
    enable_post <= r.en_post;
    @(posedge clk);
    load_state <= 1'b0;
    repeat (2) @(posedge clk);
    foreach (chars[i])
    begin
      char_in  <= chars[i];
      char_vld <= 1'b1;
      @(posedge clk);
    end
    char_vld <= 1'b0;
    repeat (2) @(posedge clk);
    eop <= 1'b1;
    @(posedge clk);
    eop <= 1'b0;
  endtask

  // Watchdog sized from the table once it is built
  initial
  begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Error: watchdog expired after %0d cycles, run did not finish", limit_cycles);
    print_counts();
    $display(">>> FAIL");
    $finish;
  end

  initial
  begin
    packet_row_t row;
    byte         chars [$];
    int          max_len;
    int          len;
    int          rst;
    int          pst;
    bit          rhit;
    bit          phit;
    bit          done;
    bit          got;
    int          lat;
    category_t   model_cat;
    clk         = 1'b0;
    rst_n       = 1'b0;
    char_in     = '0;
    char_vld    = 1'b0;
    load_state  = 1'b0;
    stream_id   = '0;
    new_stream  = 1'b0;
    eop         = 1'b0;
    enable_read = 1'b0;
    enable_post = 1'b0;
    void'($urandom(32'h42421f33));
    build_table();
    // Filler counts as its longest run of 3
    max_len = 0;
    foreach (rows[i])
    begin
      len = 0;
      for (int k = 0; k < rows[i].text.len(); k++)
        len += (rows[i].text[k] == "*") ? 3 : 1;
      if (len > max_len)
        max_len = len;
    end
    limit_cycles = rows.size() * (max_len + 19) + 55;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("reset", "verdict_vld", 0, verdict_vld);
    check_value("reset", "fired_read", 0, fired_read);
    check_value("reset", "fired_post", 0, fired_post);
    check_value("reset", "count_read", 0, count_read);
    check_value("reset", "count_post", 0, count_post);
    check_value("reset", "flagged_count", 0, flagged_count);
    foreach (rows[n])
    begin
      row = rows[n];
      chars.delete();
      for (int k = 0; k < row.text.len(); k++)
      begin
        if (row.text[k] == "*")
          repeat ($urandom_range(3, 1)) chars.push_back(byte'("a" + $urandom_range(25)));
        else
          chars.push_back(row.text[k]);
      end
      // Reference model over the exact characters sent
      rst  = row.fresh ? 0 : read_ctx[row.sid];
      pst  = row.fresh ? 0 : post_ctx[row.sid];
      rhit = 1'b0;
      phit = 1'b0;
      foreach (chars[i])
      begin
        rst  = advance_match(read_key, rst, chars[i], done);
        rhit = rhit | done;
        pst  = advance_match(post_key, pst, chars[i], done);
        phit = phit | done;
      end
      if (row.en_read)
      begin
        read_ctx[row.sid] = rst;
        exp_read_count += rhit;
      end
      if (row.en_post)
      begin
        post_ctx[row.sid] = pst;
        exp_post_count += phit;
      end
      model_cat = expected_category(rhit & row.en_read, phit & row.en_post);
      if (model_cat != CAT_NONE)
        exp_flagged++;
      check_value(row.name, "table category", row.exp, model_cat);
      drive_packet(row, chars);
      // Count edges from the eop edge until verdict_vld shows up
      got = 1'b0;
      lat = 0;
      while (!got && lat < 8)
      begin
        @(posedge clk);
        lat++;
        @(negedge clk);
        got = verdict_vld;
      end
      assert (got)
      else
      begin
        missing_errors++;
        $display("Error: test %s got no verdict_vld within 8 cycles of eop", row.name);
      end
      if (got)
      begin
        check_value(row.name, "latency", 2, lat);
        check_value(row.name, "verdict", model_cat, verdict);
        // Fired flags hold until the next load and drop at eop when disabled
        check_value(row.name, "fired_read", rhit & row.en_read, fired_read);
        check_value(row.name, "fired_post", phit & row.en_post, fired_post);
        check_value(row.name, "count_read", exp_read_count, count_read);
        check_value(row.name, "count_post", exp_post_count, count_post);
        check_value(row.name, "flagged_count", exp_flagged, flagged_count);
      end
    end
    print_counts();
    if (value_errors == 0 && missing_errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== nntp_classifier.f ====
+incdir+logic
logic/scan_pkg.sv
logic/stream_pkg.sv
logic/char_bus_if.sv
logic/keyword_scanner.sv
logic/category_tally.sv
logic/nntp_classifier.sv
sim/nntp_classifier_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
LINTFLAGS = --lint-only --timing -Wall
TOP       = nntp_classifier_tb
FILELIST  = nntp_classifier.f
BIN       = obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

# Pass only when the testbench prints the pass line
run: build
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir
